// File: rtl/fc_defs.svh
`ifndef FC_DEFS_SVH
`define FC_DEFS_SVH

////////////////////
// stream and datapath sizes
`define FC_DATA_W          32
`define FC_LANES           4
`define FC_BYTE_W          8
`define FC_ACC_W           24
`define FC_ARG_W           8

////////////////////
// memory depths and address widths
`define FC_MAX_FEAT_WORDS  16
`define FC_MAX_GROUPS      8
`define FC_WBANK_DEPTH     128    // feat words x groups
`define FC_FEAT_AW         4
`define FC_BIAS_AW         3
`define FC_WBANK_AW        7

////////////////////
// requantize
`define FC_OUT_SHIFT       6
`define FC_OUT_MAX         127

`endif

// File: rtl/fc_pkg.sv
`include "fc_defs.svh"

package fc_pkg;

  // command opcodes on cmd_op
  typedef enum logic [1:0] {
    OP_LOAD_FEAT   = 2'd0,
    OP_LOAD_BIAS   = 2'd1,
    OP_LOAD_WEIGHT = 2'd2,
    OP_RUN         = 2'd3
  } fc_opcode_e;

  // decode sequencer states
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_LOAD     = 2'd1,
    ST_RUN      = 2'd2,
    ST_WAIT_OUT = 2'd3
  } fc_state_e;

  typedef logic [`FC_DATA_W-1:0] fc_word_t;         // four int8 values
  typedef logic signed [`FC_ACC_W-1:0] fc_acc_t;    // one neuron's running sum

endpackage

// File: rtl/fc_buffers.sv
`timescale 1ns/1ps
`include "fc_defs.svh"

module fc_buffers (
  input  logic                                     clk,
  input  logic                                     feat_we,
  input  logic                                     bias_we,
  input  logic [`FC_LANES-1:0]                     wbank_we,
  input  logic [`FC_WBANK_AW-1:0]                  wr_addr,
  input  fc_pkg::fc_word_t                         wr_data,
  input  logic                                     rd_en,
  input  logic [(`FC_WBANK_AW+`FC_FEAT_AW)-1:0]    rd_addr,
  input  logic                                     bias_rd,
  input  logic [`FC_BIAS_AW-1:0]                   bias_rd_addr,
  output fc_pkg::fc_word_t                         feat_rdata,
  output fc_pkg::fc_word_t                         w_rdata0,
  output fc_pkg::fc_word_t                         w_rdata1,
  output fc_pkg::fc_word_t                         w_rdata2,
  output fc_pkg::fc_word_t                         w_rdata3,
  output fc_pkg::fc_word_t                         bias_rdata
);

  fc_pkg::fc_word_t feat_mem [`FC_MAX_FEAT_WORDS];
  fc_pkg::fc_word_t bias_mem [`FC_MAX_GROUPS];

  logic [`FC_FEAT_AW-1:0]  f_addr;
  logic [`FC_WBANK_AW-1:0] w_addr;

  // read address carries the weight address above the feature address
  assign f_addr = rd_addr[`FC_FEAT_AW-1:0];
  assign w_addr = rd_addr[`FC_FEAT_AW +: `FC_WBANK_AW];

  always_ff @(posedge clk) begin
    if (feat_we) feat_mem[wr_addr[`FC_FEAT_AW-1:0]] <= wr_data;
    if (rd_en) feat_rdata <= feat_mem[f_addr];
  end

  always_ff @(posedge clk) begin
    if (bias_we) bias_mem[wr_addr[`FC_BIAS_AW-1:0]] <= wr_data;
    if (bias_rd) bias_rdata <= bias_mem[bias_rd_addr];  // held until next bias_rd
  end

  ////////////////////
  // one weight bank per lane
  for (genvar b = 0; b < `FC_LANES; b++) begin : g_bank
    fc_pkg::fc_word_t mem [`FC_WBANK_DEPTH];
    fc_pkg::fc_word_t q;

    always_ff @(posedge clk) begin
      if (wbank_we[b]) mem[wr_addr] <= wr_data;
      if (rd_en) q <= mem[w_addr];
    end
  end

  assign w_rdata0 = g_bank[0].q;
  assign w_rdata1 = g_bank[1].q;
  assign w_rdata2 = g_bank[2].q;
  assign w_rdata3 = g_bank[3].q;

endmodule

// File: rtl/fc_decode.sv
`timescale 1ns/1ps
`include "fc_defs.svh"

module fc_decode (
  input  logic                                     clk,
  input  logic                                     rstn,
  input  logic                                     cmd_valid,
  output logic                                     cmd_ready,
  input  fc_pkg::fc_opcode_e                       cmd_op,
  input  logic [`FC_ARG_W-1:0]                     cmd_arg,
  input  logic                                     in_valid,
  output logic                                     in_ready,
  input  logic                                     out_free,
  output logic                                     feat_we,
  output logic                                     bias_we,
  output logic [`FC_LANES-1:0]                     wbank_we,
  output logic [`FC_WBANK_AW-1:0]                  wr_addr,
  output logic                                     rd_en,
  output logic [(`FC_WBANK_AW+`FC_FEAT_AW)-1:0]    rd_addr,
  output logic                                     bias_rd,
  output logic [`FC_BIAS_AW-1:0]                   bias_rd_addr,
  output logic                                     beat_valid,
  output logic                                     beat_first,
  output logic                                     beat_last,
  output logic                                     last_group
);

  localparam int FAW    = `FC_FEAT_AW;
  localparam int BAW    = `FC_BIAS_AW;
  localparam int WAW    = `FC_WBANK_AW;
  localparam int LANE_W = $clog2(`FC_LANES);
  localparam logic [2:0] DRAIN = 3'd4;  // last read until result register loads

  fc_pkg::fc_state_e  state;
  fc_pkg::fc_opcode_e op;

  logic [FAW-1:0]    k;          // feature word index
  logic [LANE_W-1:0] lane;       // neuron within group
  logic [BAW-1:0]    grp;
  logic [WAW-1:0]    wbase;      // group base in the weight banks
  logic [FAW-1:0]    feat_last;
  logic [BAW-1:0]    grp_last;
  logic [2:0]        drain;
  logic [WAW-1:0]    row_len;
  logic              take;
  logic              load_last;

  assign cmd_ready = (state == fc_pkg::ST_IDLE);
  assign in_ready  = (state == fc_pkg::ST_LOAD);
  assign take      = in_valid && in_ready;
  assign row_len   = {{(WAW-FAW){1'b0}}, feat_last} + 1'b1;

  always_comb begin
    case (op)
      fc_pkg::OP_LOAD_FEAT: load_last = (k == feat_last);
      fc_pkg::OP_LOAD_BIAS: load_last = (grp == grp_last);
      default:              load_last = (k == feat_last) && (&lane) && (grp == grp_last);
    endcase
  end

  ////////////////////
  // load side
  assign feat_we  = take && (op == fc_pkg::OP_LOAD_FEAT);
  assign bias_we  = take && (op == fc_pkg::OP_LOAD_BIAS);
  assign wbank_we = (take && op == fc_pkg::OP_LOAD_WEIGHT) ?
                    ({{(`FC_LANES-1){1'b0}}, 1'b1} << lane) : '0;

  always_comb begin
    case (op)
      fc_pkg::OP_LOAD_WEIGHT: wr_addr = wbase + {{(WAW-FAW){1'b0}}, k};
      fc_pkg::OP_LOAD_BIAS:   wr_addr = {{(WAW-BAW){1'b0}}, grp};
      default:                wr_addr = {{(WAW-FAW){1'b0}}, k};
    endcase
  end

  ////////////////////
  // run side
  assign rd_en        = (state == fc_pkg::ST_RUN);
  assign rd_addr      = {wbase + {{(WAW-FAW){1'b0}}, k}, k};
  assign bias_rd      = rd_en && (k == feat_last);   // with the group's last read
  assign bias_rd_addr = grp;
  assign last_group   = (grp == grp_last);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= fc_pkg::ST_IDLE;
      op         <= fc_pkg::OP_LOAD_FEAT;
      k          <= '0;
      lane       <= '0;
      grp        <= '0;
      wbase      <= '0;
      feat_last  <= '0;
      grp_last   <= '0;
      drain      <= '0;
      beat_valid <= 1'b0;
      beat_first <= 1'b0;
      beat_last  <= 1'b0;
    end else begin
      beat_valid <= rd_en;                    // lines up with read data
      beat_first <= rd_en && (k == '0);
      beat_last  <= bias_rd;
      case (state)
        fc_pkg::ST_IDLE: begin
          if (cmd_valid) begin
            op    <= cmd_op;
            k     <= '0;
            lane  <= '0;
            grp   <= '0;
            wbase <= '0;
            case (cmd_op)
              fc_pkg::OP_LOAD_FEAT: begin
                feat_last <= cmd_arg[FAW-1:0] - 1'b1;
                state     <= fc_pkg::ST_LOAD;
              end
              fc_pkg::OP_LOAD_BIAS: begin
                grp_last <= cmd_arg[BAW-1:0] - 1'b1;
                state    <= fc_pkg::ST_LOAD;
              end
              fc_pkg::OP_LOAD_WEIGHT: state <= fc_pkg::ST_LOAD;
              fc_pkg::OP_RUN:         state <= fc_pkg::ST_RUN;
            endcase
          end
        end
        fc_pkg::ST_LOAD: begin
          if (take) begin
            if (load_last) state <= fc_pkg::ST_IDLE;
            if (op == fc_pkg::OP_LOAD_BIAS) begin
              grp <= grp + 1'b1;
            end else if (k == feat_last) begin   // end of a neuron row
              k    <= '0;
              lane <= lane + 1'b1;
              if (&lane) begin
                grp   <= grp + 1'b1;
                wbase <= wbase + row_len;
              end
            end else begin
              k <= k + 1'b1;
            end
          end
        end
        fc_pkg::ST_RUN: begin
          if (k == feat_last) begin
            k     <= '0;
            drain <= DRAIN;
            state <= fc_pkg::ST_WAIT_OUT;
          end else begin
            k <= k + 1'b1;
          end
        end
        fc_pkg::ST_WAIT_OUT: begin
          if (drain != '0) begin
            drain <= drain - 1'b1;
          end else if (out_free) begin
            if (last_group) begin
              state <= fc_pkg::ST_IDLE;
            end else begin
              grp   <= grp + 1'b1;
              wbase <= wbase + row_len;
              state <= fc_pkg::ST_RUN;
            end
          end
        end
      endcase
    end
  end

  a_ready_only_in_load : assert property (@(posedge clk) disable iff (!rstn)
    in_ready |-> state == fc_pkg::ST_LOAD);

endmodule

// File: rtl/fc_execute.sv
`timescale 1ns/1ps
`include "fc_defs.svh"

module fc_execute (
  input  logic              clk,
  input  logic              rstn,
  input  logic              beat_valid,
  input  logic              beat_first,
  input  logic              beat_last,
  input  fc_pkg::fc_word_t  feat_rdata,
  input  fc_pkg::fc_word_t  w_rdata0,
  input  fc_pkg::fc_word_t  w_rdata1,
  input  fc_pkg::fc_word_t  w_rdata2,
  input  fc_pkg::fc_word_t  w_rdata3,
  output logic              acc_valid,
  output fc_pkg::fc_acc_t   acc0,
  output fc_pkg::fc_acc_t   acc1,
  output fc_pkg::fc_acc_t   acc2,
  output fc_pkg::fc_acc_t   acc3
);

  localparam int LANES = `FC_LANES;
  localparam int BYTES = `FC_DATA_W / `FC_BYTE_W;
  localparam int BW    = `FC_BYTE_W;

  fc_pkg::fc_word_t w_word [LANES];
  fc_pkg::fc_acc_t  acc_q  [LANES];

  logic s1_valid, s1_first, s1_last;
  logic s2_valid, s2_first, s2_last;

  assign w_word[0] = w_rdata0;
  assign w_word[1] = w_rdata1;
  assign w_word[2] = w_rdata2;
  assign w_word[3] = w_rdata3;

  ////////////////////
  // beat flags ride along the pipe
  always_ff @(posedge clk) begin
    if (!rstn) begin
      s1_valid  <= 1'b0;
      s1_first  <= 1'b0;
      s1_last   <= 1'b0;
      s2_valid  <= 1'b0;
      s2_first  <= 1'b0;
      s2_last   <= 1'b0;
      acc_valid <= 1'b0;
    end else begin
      s1_valid  <= beat_valid;
      s1_first  <= beat_valid && beat_first;
      s1_last   <= beat_valid && beat_last;
      s2_valid  <= s1_valid;
      s2_first  <= s1_first;
      s2_last   <= s1_last;
      acc_valid <= s2_valid && s2_last;   // one pulse per group
    end
  end

  ////////////////////
  // lanes
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    logic signed [2*BW-1:0] prod [BYTES];
    fc_pkg::fc_acc_t        sum;

    // stage 1 registers the byte products
    for (genvar b = 0; b < BYTES; b++) begin : g_mul
      always_ff @(posedge clk) begin
        prod[b] <= $signed(feat_rdata[BW*b +: BW]) * $signed(w_word[l][BW*b +: BW]);
      end
    end

    // stage 2 sums them per lane
    always_ff @(posedge clk) begin
      sum <= prod[0] + prod[1] + prod[2] + prod[3];
    end

    // stage 3 accumulates and restarts on a first beat
    always_ff @(posedge clk) begin
      if (s2_valid) begin
        if (s2_first) acc_q[l] <= sum;
        else acc_q[l] <= acc_q[l] + sum;
      end
    end
  end

  assign acc0 = acc_q[0];
  assign acc1 = acc_q[1];
  assign acc2 = acc_q[2];
  assign acc3 = acc_q[3];

endmodule

// File: rtl/fc_result.sv
`timescale 1ns/1ps
`include "fc_defs.svh"

module fc_result (
  input  logic              clk,
  input  logic              rstn,
  input  logic              acc_valid,
  input  fc_pkg::fc_acc_t   acc0,
  input  fc_pkg::fc_acc_t   acc1,
  input  fc_pkg::fc_acc_t   acc2,
  input  fc_pkg::fc_acc_t   acc3,
  input  fc_pkg::fc_word_t  bias_rdata,
  input  logic              last_group,
  input  logic              out_ready,
  output logic              out_valid,
  output fc_pkg::fc_word_t  out_data,
  output logic              out_last,
  output logic              done,
  output logic              out_free
);

  localparam int LANES = `FC_LANES;
  localparam int BW    = `FC_BYTE_W;

  fc_pkg::fc_acc_t  acc_in  [LANES];
  fc_pkg::fc_acc_t  biased  [LANES];
  fc_pkg::fc_acc_t  shifted [LANES];
  logic [BW-1:0]    q       [LANES];
  fc_pkg::fc_word_t packed_word;
  logic             xfer;

  assign acc_in[0] = acc0;
  assign acc_in[1] = acc1;
  assign acc_in[2] = acc2;
  assign acc_in[3] = acc3;

  ////////////////////
  // bias, relu, requantize
  for (genvar l = 0; l < LANES; l++) begin : g_quant
    assign biased[l]  = acc_in[l] + $signed(bias_rdata[BW*l +: BW]);
    assign shifted[l] = biased[l] >>> `FC_OUT_SHIFT;
    assign q[l] = biased[l][`FC_ACC_W-1] ? '0 :              // relu
                  (shifted[l] > `FC_OUT_MAX) ? BW'(`FC_OUT_MAX) :
                  shifted[l][BW-1:0];
    assign packed_word[BW*l +: BW] = q[l];                     // lane 0 in low byte
  end

  assign xfer     = out_valid && out_ready;
  assign out_free = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= xfer && out_last;
      if (acc_valid) begin
        out_valid <= 1'b1;
        out_last  <= last_group;
      end else if (xfer) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) out_data <= packed_word;
  end

  a_out_hold : assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> $stable(out_data) && $stable(out_last));

  // decode only releases a group once the register can take it
  a_no_overrun : assert property (@(posedge clk) disable iff (!rstn)
    acc_valid |-> out_free);

endmodule

// File: rtl/fc_top.sv
`timescale 1ns/1ps
`include "fc_defs.svh"

module fc_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  fc_pkg::fc_opcode_e    cmd_op,
  input  logic [`FC_ARG_W-1:0]  cmd_arg,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fc_pkg::fc_word_t      in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fc_pkg::fc_word_t      out_data,
  output logic                  out_last,
  output logic                  done
);

  logic                                  feat_we, bias_we;
  logic [`FC_LANES-1:0]                  wbank_we;
  logic [`FC_WBANK_AW-1:0]               wr_addr;
  logic                                  rd_en, bias_rd;
  logic [(`FC_WBANK_AW+`FC_FEAT_AW)-1:0] rd_addr;
  logic [`FC_BIAS_AW-1:0]                bias_rd_addr;
  logic                                  beat_valid, beat_first, beat_last;
  logic                                  last_group, out_free, acc_valid;
  fc_pkg::fc_word_t                      feat_rdata, bias_rdata;
  fc_pkg::fc_word_t                      w_rdata0, w_rdata1, w_rdata2, w_rdata3;
  fc_pkg::fc_acc_t                       acc0, acc1, acc2, acc3;

  fc_decode i_decode (
    .clk, .rstn, .cmd_valid, .cmd_ready, .cmd_op, .cmd_arg,
    .in_valid, .in_ready, .out_free,
    .feat_we, .bias_we, .wbank_we, .wr_addr,
    .rd_en, .rd_addr, .bias_rd, .bias_rd_addr,
    .beat_valid, .beat_first, .beat_last, .last_group
  );

  fc_buffers i_buffers (
    .clk, .feat_we, .bias_we, .wbank_we, .wr_addr,
    .wr_data (in_data),                  // stream words go straight in
    .rd_en, .rd_addr, .bias_rd, .bias_rd_addr,
    .feat_rdata, .w_rdata0, .w_rdata1, .w_rdata2, .w_rdata3, .bias_rdata
  );

  fc_execute i_execute (
    .clk, .rstn, .beat_valid, .beat_first, .beat_last,
    .feat_rdata, .w_rdata0, .w_rdata1, .w_rdata2, .w_rdata3,
    .acc_valid, .acc0, .acc1, .acc2, .acc3
  );

  fc_result i_result (
    .clk, .rstn, .acc_valid, .acc0, .acc1, .acc2, .acc3,
    .bias_rdata, .last_group, .out_ready,
    .out_valid, .out_data, .out_last, .done, .out_free
  );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rstn
);

  initial clk = 1'b0;
  always #5 clk = ~clk;   // 10 ns period

  // reset low for 8 cycles, released on a falling edge
  initial begin
    rstn = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// File: tests/tb_fc.sv
`timescale 1ns/1ps
`include "fc_defs.svh"

module tb_fc;

  localparam int TIMEOUT = 1000;   // cycles per wait

  logic                 clk, rstn;
  logic                 cmd_valid, cmd_ready, in_valid, in_ready;
  logic                 out_valid, out_ready, out_last, done;
  fc_pkg::fc_opcode_e   cmd_op;
  logic [`FC_ARG_W-1:0] cmd_arg;
  fc_pkg::fc_word_t     in_data, out_data;

  integer           fd;
  integer           seed;
  string            test_name;
  int               n_feat, n_grp, n_wts;
  fc_pkg::fc_word_t feat [`FC_MAX_FEAT_WORDS];
  fc_pkg::fc_word_t bias [`FC_MAX_GROUPS];
  fc_pkg::fc_word_t wts  [`FC_WBANK_DEPTH*`FC_LANES];
  fc_pkg::fc_word_t expw [`FC_MAX_GROUPS];

  tb_clock i_clock (.clk, .rstn);

  fc_top i_fc_top (
    .clk, .rstn, .cmd_valid, .cmd_ready, .cmd_op, .cmd_arg,
    .in_valid, .in_ready, .in_data,
    .out_valid, .out_ready, .out_data, .out_last, .done
  );

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch in %s", test_name);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "%s", msg);
  endtask

  ////////////////////
  // data file reading
  task automatic read_token(output string tok);
    string line;
    int    r;
    r = $fscanf(fd, "%s", tok);
    while (r == 1 && tok.getc(0) == "#") begin   // comment up to end of line
      r = $fgets(line, fd);
      r = $fscanf(fd, "%s", tok);
    end
    if (r != 1) tok = "";
  endtask

  task automatic read_word(output fc_pkg::fc_word_t w);
    string tok;
    read_token(tok);
    if (tok == "") abort_run("data file ends in the middle of a record");
    w = fc_pkg::fc_word_t'(tok.atohex());
  endtask

  ////////////////////
  // command and input stream handshakes, called on a falling edge
  task automatic send_cmd(input fc_pkg::fc_opcode_e op, input logic [`FC_ARG_W-1:0] arg);
    int n;
    n         = 0;
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_arg   = arg;
    while (!cmd_ready) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("cmd_ready stayed low, command was never accepted");
    end
    @(negedge clk);   // taken on the rising edge in between
    cmd_valid = 1'b0;
  endtask

  task automatic send_word(input fc_pkg::fc_word_t w);
    int n;
    n        = 0;
    in_valid = 1'b1;
    in_data  = w;
    while (!in_ready) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("in_ready stayed low, input word was never taken");
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic load_record();
    send_cmd(fc_pkg::OP_LOAD_FEAT, `FC_ARG_W'(n_feat));
    for (int i = 0; i < n_feat; i++) send_word(feat[i]);
    send_cmd(fc_pkg::OP_LOAD_BIAS, `FC_ARG_W'(n_grp));
    for (int i = 0; i < n_grp; i++) send_word(bias[i]);
    send_cmd(fc_pkg::OP_LOAD_WEIGHT, '0);   // length set by the two loads above
    for (int i = 0; i < n_wts; i++) send_word(wts[i]);
  endtask

  // collect one run under random out_ready
  task automatic run_and_check();
    int               idx;
    int               n;
    logic             held;
    fc_pkg::fc_word_t last_data;
    idx       = 0;
    n         = 0;
    held      = 1'b0;
    last_data = '0;
    send_cmd(fc_pkg::OP_RUN, '0);
    while (idx < n_grp) begin
      if (held) check("out_data held while stalled", last_data, out_data);
      check("done before last word", 0, done);
      out_ready = ($random(seed) & 32'd1) != 0;
      if (out_valid && out_ready) begin
        check($sformatf("word %0d", idx), expw[idx], out_data);
        check($sformatf("out_last on word %0d", idx), (idx == n_grp - 1), out_last);
        idx++;
      end
      held      = out_valid && !out_ready;
      last_data = out_data;
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("out_valid never delivered all words of the run");
    end
    out_ready = 1'b0;
    check("done after last word", 1, done);
    @(negedge clk);
    check("done pulse length", 0, done);
  endtask

  initial begin
    string tok;
    int    records;
    int    n;
    cmd_valid = 1'b0;
    cmd_op    = fc_pkg::OP_LOAD_FEAT;
    cmd_arg   = '0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    seed      = 32'h62be;
    records   = 0;
    n         = 0;
    test_name = "reset";
    fd = $fopen("tests/fc_tests.dat", "r");
    if (fd == 0) abort_run("cannot open tests/fc_tests.dat");

    @(posedge clk);
    while (!rstn) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) abort_run("rstn never went high");
    end
    @(negedge clk);
    check("cmd_ready", 1, cmd_ready);
    check("in_ready", 0, in_ready);
    check("out_valid", 0, out_valid);
    check("done", 0, done);

    read_token(tok);
    while (tok != "") begin
      test_name = tok;
      read_token(tok);
      n_feat = tok.atoi();
      read_token(tok);
      n_grp = tok.atoi();
      if (n_feat < 1 || n_feat > `FC_MAX_FEAT_WORDS || n_grp < 1 || n_grp > `FC_MAX_GROUPS)
        abort_run("record header has a bad feature or group count");
      n_wts = n_grp * `FC_LANES * n_feat;
      for (int i = 0; i < n_feat; i++) read_word(feat[i]);
      for (int i = 0; i < n_grp; i++) read_word(bias[i]);
      for (int i = 0; i < n_wts; i++) read_word(wts[i]);
      for (int i = 0; i < n_grp; i++) read_word(expw[i]);
      load_record();
      run_and_check();
      records++;
      read_token(tok);
    end
    $fclose(fd);

    if (records < 2) abort_run("data file holds fewer than two records");
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+rtl
rtl/fc_pkg.sv
rtl/fc_buffers.sv
rtl/fc_decode.sv
rtl/fc_execute.sv
rtl/fc_result.sv
rtl/fc_top.sv
tests/tb_clock.sv
tests/tb_fc.sv

// File: run.sh
#!/bin/sh
# build and run the fc layer testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_fc \
    -f filelist.f -o tb_fc; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_fc; then
  echo "simulation failed"
  exit 1
fi

echo "simulation finished"
exit 0

// File: tests/fc_tests.dat
# record: name feat_words groups, then feature words, bias words (one per group),
# weight words (neuron rows in order), expected output words; all words hex, byte 0 low
# lane 1 saturates, lanes 2 and 7 go negative and clamp to 0
mixed_2x2 2 2
03FB140A 01329C64
24F60064 7FFF0738
01010101 00000000 00000000 0000007F 0000FFFF 00000000 00000002 00040000
00000000 0000FE00 03030303 01000001 00800000 007F0000 00000000 00000080
04007F02 006D0304
# new features and a shorter row, same bias words and first weight column
reload_1x2 1 2
7F07EC32
24F60064 7FFF0738
01010101 00000000 0000FFFF 00000002 00000000 03030303 00800000 00000000
02000004 01000700
